//--- Makefile
TOP := tb_ball_tracker

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)
	verilator --lint-only --timing --assert -f tb.f --top-module ball_tracker_top

clean:
	rm -rf obj_dir sim.log

//--- ball_detect.sv
module ball_detect (
	input  logic                        vga_clk,
	input  logic                        rst_n,
	input  logic                        detect_en,
	input  logic [vga_pkg::COORD_W-1:0] pix_x,
	input  logic [vga_pkg::COORD_W-1:0] pix_y,
	input  logic                        pixel_req,
	input  logic                        hs,
	input  logic                        vs,
	input  logic [vga_pkg::COLOR_W-1:0] pix_r,
	input  logic [vga_pkg::COLOR_W-1:0] pix_g,
	input  logic [vga_pkg::COLOR_W-1:0] pix_b,
	output logic [vga_pkg::COLOR_W-1:0] mark_r,
	output logic [vga_pkg::COLOR_W-1:0] mark_g,
	output logic [vga_pkg::COLOR_W-1:0] mark_b,
	output logic [vga_pkg::COORD_W-1:0] mark_x,
	output logic [vga_pkg::COORD_W-1:0] mark_y,
	output logic                        mark_de,
	output logic                        mark_hs,
	output logic                        mark_vs,
	output logic                        ball_found,
	output logic [vga_pkg::COORD_W-1:0] ball_x,
	output logic [vga_pkg::COORD_W-1:0] ball_y
);

	// Timing delayed one cycle, lines up with the returned pixel
	logic [vga_pkg::COORD_W-1:0] d_x;
	logic [vga_pkg::COORD_W-1:0] d_y;
	logic                        d_de;
	logic                        d_hs;
	logic                        d_vs;

	// Box growing over the current frame
	logic [vga_pkg::COORD_W-1:0] run_x0;
	logic [vga_pkg::COORD_W-1:0] run_x1;
	logic [vga_pkg::COORD_W-1:0] run_y0;
	logic [vga_pkg::COORD_W-1:0] run_y1;
	logic                        run_hit;

	// Box of the previous frame
	logic [vga_pkg::COORD_W-1:0] box_x0;
	logic [vga_pkg::COORD_W-1:0] box_x1;
	logic [vga_pkg::COORD_W-1:0] box_y0;
	logic [vga_pkg::COORD_W-1:0] box_y1;

	logic [vga_pkg::COORD_W:0]   sum_x;
	logic [vga_pkg::COORD_W:0]   sum_y;
	logic                        is_ball;
	logic                        frame_end;
	logic                        in_xspan;
	logic                        in_yspan;
	logic                        on_edge;
	logic                        do_mark;

	//======================================================================
	// Classification
	//======================================================================

	assign is_ball = d_de && int'(pix_r) >= vga_pkg::BALL_R_MIN &&
		int'(pix_g) < vga_pkg::BALL_GB_MAX && int'(pix_b) < vga_pkg::BALL_GB_MAX;

	// First blank line, column 0
	assign frame_end = int'(d_y) == vga_pkg::V_ACTIVE && d_x == '0;

	// One extra bit so the midpoint does not overflow
	assign sum_x = {1'b0, run_x0} + {1'b0, run_x1};
	assign sum_y = {1'b0, run_y0} + {1'b0, run_y1};

	// Edge rows and columns, clipped to the box span
	assign in_xspan = d_x >= box_x0 && d_x <= box_x1;
	assign in_yspan = d_y >= box_y0 && d_y <= box_y1;
	assign on_edge  = ((d_y == box_y0 || d_y == box_y1) && in_xspan) ||
		((d_x == box_x0 || d_x == box_x1) && in_yspan);
	assign do_mark  = detect_en && ball_found && d_de && on_edge;

	//======================================================================
	// Control and box state
	//======================================================================

	always_ff @(posedge vga_clk) begin
		if (!rst_n) begin
			d_de       <= 1'b0;
			d_hs       <= 1'b1;
			d_vs       <= 1'b1;
			mark_de    <= 1'b0;
			mark_hs    <= 1'b1;
			mark_vs    <= 1'b1;
			run_hit    <= 1'b0;
			run_x0     <= '1;
			run_x1     <= '0;
			run_y0     <= '1;
			run_y1     <= '0;
			ball_found <= 1'b0;
			ball_x     <= '0;
			ball_y     <= '0;
		end else begin
			d_de    <= pixel_req;
			d_hs    <= hs;
			d_vs    <= vs;
			mark_de <= d_de;
			mark_hs <= d_hs;
			mark_vs <= d_vs;
			if (frame_end) begin
				// Publish the result, then restart the search
				ball_found <= run_hit;
				ball_x     <= sum_x[vga_pkg::COORD_W:1];
				ball_y     <= sum_y[vga_pkg::COORD_W:1];
				run_hit    <= 1'b0;
				run_x0     <= '1;
				run_x1     <= '0;
				run_y0     <= '1;
				run_y1     <= '0;
			end else if (is_ball) begin
				run_hit <= 1'b1;
				if (d_x < run_x0) begin
					run_x0 <= d_x;
				end
				if (d_x > run_x1) begin
					run_x1 <= d_x;
				end
				if (d_y < run_y0) begin
					run_y0 <= d_y;
				end
				if (d_y > run_y1) begin
					run_y1 <= d_y;
				end
			end
		end
	end

	//======================================================================
	// Pixel path
	//======================================================================

	always_ff @(posedge vga_clk) begin
		d_x    <= pix_x;
		d_y    <= pix_y;
		mark_x <= d_x;
		mark_y <= d_y;
		if (do_mark) begin
			mark_r <= vga_pkg::MARK_R;
			mark_g <= vga_pkg::MARK_G;
			mark_b <= vga_pkg::MARK_B;
		end else begin
			mark_r <= pix_r;
			mark_g <= pix_g;
			mark_b <= pix_b;
		end
		// Held for the whole next frame
		if (frame_end) begin
			box_x0 <= run_x0;
			box_x1 <= run_x1;
			box_y0 <= run_y0;
			box_y1 <= run_y1;
		end
	end

	// A reported ball always comes with a well-formed box
	a_box_order: assert property (@(posedge vga_clk) disable iff (!rst_n)
		ball_found |-> box_x0 <= box_x1 && box_y0 <= box_y1);

endmodule

//--- ball_tracker_top.sv
module ball_tracker_top (
	input  logic                        vga_clk,
	input  logic                        rst_n,
	input  logic                        detect_en,
	input  logic                        overlay_en,
	input  logic [vga_pkg::SCORE_W-1:0] score_a,
	input  logic [vga_pkg::SCORE_W-1:0] score_b,
	// Frame store answer, one cycle after the request
	input  logic [vga_pkg::COLOR_W-1:0] pix_r,
	input  logic [vga_pkg::COLOR_W-1:0] pix_g,
	input  logic [vga_pkg::COLOR_W-1:0] pix_b,
	// Frame store request
	output logic [vga_pkg::COORD_W-1:0] pix_x,
	output logic [vga_pkg::COORD_W-1:0] pix_y,
	output logic                        pixel_req,
	// Monitor
	output logic [vga_pkg::COLOR_W-1:0] vga_r,
	output logic [vga_pkg::COLOR_W-1:0] vga_g,
	output logic [vga_pkg::COLOR_W-1:0] vga_b,
	output logic                        vga_hs,
	output logic                        vga_vs,
	output logic                        vga_blank_n,
	// Per-frame result
	output logic                        ball_found,
	output logic [vga_pkg::COORD_W-1:0] ball_x,
	output logic [vga_pkg::COORD_W-1:0] ball_y,
	// Seven-segment
	output logic [6:0]                  hex0,
	output logic [6:0]                  hex1,
	output logic [6:0]                  hex2,
	output logic [6:0]                  hex3
);

	//======================================================================
	// Stage wiring
	//======================================================================

	// Syncs from the timing generator
	logic                        tim_hs;
	logic                        tim_vs;
	// Detect stage to overlay stage
	logic [vga_pkg::COLOR_W-1:0] mark_r;
	logic [vga_pkg::COLOR_W-1:0] mark_g;
	logic [vga_pkg::COLOR_W-1:0] mark_b;
	logic [vga_pkg::COORD_W-1:0] mark_x;
	logic [vga_pkg::COORD_W-1:0] mark_y;
	logic                        mark_de;
	logic                        mark_hs;
	logic                        mark_vs;

	vga_timing vga_timing_inst (
		.vga_clk  (vga_clk  ),
		.rst_n    (rst_n    ),
		.pix_x    (pix_x    ),
		.pix_y    (pix_y    ),
		.pixel_req(pixel_req),
		.hs       (tim_hs   ),
		.vs       (tim_vs   )
	);

	ball_detect ball_detect_inst (
		.vga_clk   (vga_clk   ),
		.rst_n     (rst_n     ),
		.detect_en (detect_en ),
		.pix_x     (pix_x     ),
		.pix_y     (pix_y     ),
		.pixel_req (pixel_req ),
		.hs        (tim_hs    ),
		.vs        (tim_vs    ),
		.pix_r     (pix_r     ),
		.pix_g     (pix_g     ),
		.pix_b     (pix_b     ),
		.mark_r    (mark_r    ),
		.mark_g    (mark_g    ),
		.mark_b    (mark_b    ),
		.mark_x    (mark_x    ),
		.mark_y    (mark_y    ),
		.mark_de   (mark_de   ),
		.mark_hs   (mark_hs   ),
		.mark_vs   (mark_vs   ),
		.ball_found(ball_found),
		.ball_x    (ball_x    ),
		.ball_y    (ball_y    )
	);

	score_overlay score_overlay_inst (
		.vga_clk    (vga_clk    ),
		.rst_n      (rst_n      ),
		.overlay_en (overlay_en ),
		.score_a    (score_a    ),
		.score_b    (score_b    ),
		.mark_r     (mark_r     ),
		.mark_g     (mark_g     ),
		.mark_b     (mark_b     ),
		.mark_x     (mark_x     ),
		.mark_y     (mark_y     ),
		.mark_de    (mark_de    ),
		.mark_hs    (mark_hs    ),
		.mark_vs    (mark_vs    ),
		.vga_r      (vga_r      ),
		.vga_g      (vga_g      ),
		.vga_b      (vga_b      ),
		.vga_hs     (vga_hs     ),
		.vga_vs     (vga_vs     ),
		.vga_blank_n(vga_blank_n)
	);

	// Combinational, no clock
	score_hex score_hex_inst (
		.score_a(score_a),
		.score_b(score_b),
		.hex0   (hex0   ),
		.hex1   (hex1   ),
		.hex2   (hex2   ),
		.hex3   (hex3   )
	);

endmodule

//--- score_hex.sv
module score_hex (
	input  logic [vga_pkg::SCORE_W-1:0] score_a,
	input  logic [vga_pkg::SCORE_W-1:0] score_b,
	output logic [6:0]                  hex0,
	output logic [6:0]                  hex1,
	output logic [6:0]                  hex2,
	output logic [6:0]                  hex3
);

	// Tens digit in the upper half, units in the lower
	function automatic logic [13:0] seg_pair(input logic [vga_pkg::SCORE_W-1:0] s);
		int tens;
		int units;
		// Out of range shows two dashes
		if (int'(s) > vga_pkg::SCORE_MAX) begin
			return {vga_pkg::SEG_DASH, vga_pkg::SEG_DASH};
		end
		tens  = int'(s) / 10;
		units = int'(s) % 10;
		// Leading zero stays lit
		return {vga_pkg::SEG_DIGITS[tens], vga_pkg::SEG_DIGITS[units]};
	endfunction

	//======================================================================
	// Digit mapping
	//======================================================================

	// Player A on the right pair
	assign {hex1, hex0} = seg_pair(score_a);
	// Player B on the left pair
	assign {hex3, hex2} = seg_pair(score_b);

endmodule

//--- score_overlay.sv
module score_overlay (
	input  logic                        vga_clk,
	input  logic                        rst_n,
	input  logic                        overlay_en,
	input  logic [vga_pkg::SCORE_W-1:0] score_a,
	input  logic [vga_pkg::SCORE_W-1:0] score_b,
	input  logic [vga_pkg::COLOR_W-1:0] mark_r,
	input  logic [vga_pkg::COLOR_W-1:0] mark_g,
	input  logic [vga_pkg::COLOR_W-1:0] mark_b,
	input  logic [vga_pkg::COORD_W-1:0] mark_x,
	input  logic [vga_pkg::COORD_W-1:0] mark_y,
	input  logic                        mark_de,
	input  logic                        mark_hs,
	input  logic                        mark_vs,
	output logic [vga_pkg::COLOR_W-1:0] vga_r,
	output logic [vga_pkg::COLOR_W-1:0] vga_g,
	output logic [vga_pkg::COLOR_W-1:0] vga_b,
	output logic                        vga_hs,
	output logic                        vga_vs,
	output logic                        vga_blank_n
);

	// Bar lengths in pixels
	int   len_a;
	int   len_b;
	logic in_rows;
	logic in_bar_a;
	logic in_bar_b;

	// Scores saturate before scaling
	assign len_a = vga_pkg::BAR_STEP *
		((int'(score_a) > vga_pkg::SCORE_MAX) ? vga_pkg::SCORE_MAX : int'(score_a));
	assign len_b = vga_pkg::BAR_STEP *
		((int'(score_b) > vga_pkg::SCORE_MAX) ? vga_pkg::SCORE_MAX : int'(score_b));

	assign in_rows = overlay_en &&
		int'(mark_y) >= vga_pkg::BAR_TOP && int'(mark_y) <= vga_pkg::BAR_BOTTOM;

	// Bar A from the left edge
	assign in_bar_a = in_rows && int'(mark_x) >= vga_pkg::BAR_LEFT &&
		int'(mark_x) < vga_pkg::BAR_LEFT + len_a;
	// Bar B ends at the right edge
	assign in_bar_b = in_rows && int'(mark_x) >= vga_pkg::BAR_RIGHT - len_b &&
		int'(mark_x) < vga_pkg::BAR_RIGHT;

	//======================================================================
	// Output register
	//======================================================================

	always_ff @(posedge vga_clk) begin
		if (!rst_n) begin
			{vga_r, vga_g, vga_b} <= '0;
			vga_hs      <= 1'b1;
			vga_vs      <= 1'b1;
			vga_blank_n <= 1'b0;
		end else begin
			vga_hs      <= mark_hs;
			vga_vs      <= mark_vs;
			vga_blank_n <= mark_de;
			if (!mark_de) begin
				// Black during blanking
				{vga_r, vga_g, vga_b} <= '0;
			end else if (in_bar_a) begin
				{vga_r, vga_g, vga_b} <= vga_pkg::BAR_A_COLOR;
			end else if (in_bar_b) begin
				{vga_r, vga_g, vga_b} <= vga_pkg::BAR_B_COLOR;
			end else begin
				{vga_r, vga_g, vga_b} <= {mark_r, mark_g, mark_b};
			end
		end
	end

endmodule

//--- tb.f
vga_pkg.sv
vga_timing.sv
ball_detect.sv
score_overlay.sv
score_hex.sv
ball_tracker_top.sv
tb_ball_tracker.sv

//--- tb_ball_tracker.sv
module tb_ball_tracker;
	timeunit 1ns;
	timeprecision 100ps;

	// Five full frames of raster time
	localparam int TIMEOUT_CYCLES = 5 * vga_pkg::H_TOTAL * vga_pkg::V_TOTAL;
	// Blank line where results are read and the next frame is set up
	localparam int SETUP_LINE = 500;
	// One sample of reset outputs plus the three pipeline stages
	localparam int FILL_CYCLES = 4;

	logic                        clk = 1'b0;
	logic                        rst_n;
	logic                        detect_en;
	logic                        overlay_en;
	logic [vga_pkg::SCORE_W-1:0] score_a;
	logic [vga_pkg::SCORE_W-1:0] score_b;
	logic [vga_pkg::COLOR_W-1:0] pix_r = '0;
	logic [vga_pkg::COLOR_W-1:0] pix_g = '0;
	logic [vga_pkg::COLOR_W-1:0] pix_b = '0;
	logic [vga_pkg::COORD_W-1:0] pix_x;
	logic [vga_pkg::COORD_W-1:0] pix_y;
	logic                        pixel_req;
	logic [vga_pkg::COLOR_W-1:0] vga_r;
	logic [vga_pkg::COLOR_W-1:0] vga_g;
	logic [vga_pkg::COLOR_W-1:0] vga_b;
	logic                        vga_hs;
	logic                        vga_vs;
	logic                        vga_blank_n;
	logic                        ball_found;
	logic [vga_pkg::COORD_W-1:0] ball_x;
	logic [vga_pkg::COORD_W-1:0] ball_y;
	logic [6:0]                  hex0;
	logic [6:0]                  hex1;
	logic [6:0]                  hex2;
	logic [6:0]                  hex3;

	// Red square of the current frame
	logic sq_on = 1'b0;
	int   sq_x0 = 0;
	int   sq_x1 = 0;
	int   sq_y0 = 0;
	int   sq_y1 = 0;
	// Square of the previous frame, the box the DUT should outline
	logic prev_on = 1'b0;
	int   box_x0 = 0;
	int   box_x1 = 0;
	int   box_y0 = 0;
	int   box_y1 = 0;

	// Request history {req, y, x}, index 2 lines up with the outputs
	logic [20:0] hist [3];
	logic [23:0] exp_rgb;
	logic hist_act;
	// Raster position the request port should show
	int ras_x;
	int ras_y;
	int fill;
	int hs_low;
	int hs_gap;
	int hs_falls;
	int vs_low;
	int vs_gap;
	int vs_falls;
	logic hs_prev;
	logic vs_prev;
	int err_sync;
	int err_outline;
	int err_bars;
	int err_ball;
	int err_seg;
	int err_misc;
	int seed;
	int frame;
	int cycles;
	int total;
	int failed;

	ball_tracker_top u_ball_tracker_top (.vga_clk(clk), .*);

	always #20 clk = ~clk;

	//======================================================================
	// Reference rules
	//======================================================================

	function automatic int saturate(input int s);
		return (s > vga_pkg::SCORE_MAX) ? vga_pkg::SCORE_MAX : s;
	endfunction

	function automatic logic bar_rows(input int y);
		return overlay_en && y >= vga_pkg::BAR_TOP && y <= vga_pkg::BAR_BOTTOM;
	endfunction

	// Gray background, red square
	function automatic logic [23:0] source_rgb(input int x, input int y);
		if (sq_on && x >= sq_x0 && x <= sq_x1 && y >= sq_y0 && y <= sq_y1) begin
			return 24'hff0000;
		end
		return 24'h646464;
	endfunction

	function automatic logic [23:0] expected_rgb(input int x, input int y, input logic req);
		int   len_a;
		int   len_b;
		logic edge_x;
		logic edge_y;
		if (!req) begin
			return '0;
		end
		len_a = vga_pkg::BAR_STEP * saturate(int'(score_a));
		len_b = vga_pkg::BAR_STEP * saturate(int'(score_b));
		// Bars sit on top of everything
		if (bar_rows(y) && x >= vga_pkg::BAR_LEFT && x < vga_pkg::BAR_LEFT + len_a) begin
			return vga_pkg::BAR_A_COLOR;
		end
		if (bar_rows(y) && x >= vga_pkg::BAR_RIGHT - len_b && x < vga_pkg::BAR_RIGHT) begin
			return vga_pkg::BAR_B_COLOR;
		end
		edge_x = (x == box_x0 || x == box_x1) && y >= box_y0 && y <= box_y1;
		edge_y = (y == box_y0 || y == box_y1) && x >= box_x0 && x <= box_x1;
		if (detect_en && prev_on && (edge_x || edge_y)) begin
			return 24'h00ff00;
		end
		return source_rgb(x, y);
	endfunction

	// Decimal digit by repeated subtraction, dash when out of range
	function automatic logic [6:0] digit_pattern(input int s, input logic tens_digit);
		int t;
		int u;
		if (s > vga_pkg::SCORE_MAX) begin
			return vga_pkg::SEG_DASH;
		end
		t = 0;
		u = s;
		while (u >= 10) begin
			u = u - 10;
			t = t + 1;
		end
		return tens_digit ? vga_pkg::SEG_DIGITS[t] : vga_pkg::SEG_DIGITS[u];
	endfunction

	task automatic show_error(input string msg);
		$display("** Error at %0t: %s", $time, msg);
	endtask

	task automatic report_test(input string name, input int errs);
		$display("Test %s: %s with %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
	endtask

	//======================================================================
	// Frame store, answers one cycle after the request
	//======================================================================

	always @(posedge clk) begin
		if (pixel_req) begin
			{pix_r, pix_g, pix_b} <= source_rgb(int'(pix_x), int'(pix_y));
		end else begin
			{pix_r, pix_g, pix_b} <= '0;
		end
	end

	//======================================================================
	// Output monitor
	//======================================================================

	always @(posedge clk) begin
		if (!rst_n) begin
			hist[0]  <= '0;
			hist[1]  <= '0;
			hist[2]  <= '0;
			fill     <= 0;
			ras_x    <= 0;
			ras_y    <= 0;
			hs_prev  <= 1'b1;
			vs_prev  <= 1'b1;
			hs_low   <= 0;
			vs_low   <= 0;
			hs_gap   <= 0;
			vs_gap   <= 0;
			hs_falls <= 0;
			vs_falls <= 0;
		end else begin
			hist[0] <= {pixel_req, pix_y, pix_x};
			hist[1] <= hist[0];
			hist[2] <= hist[1];
			if (fill < FILL_CYCLES) begin
				fill <= fill + 1;
			end
			// Request port walks the raster from (0,0) once the counters run
			if (fill > 0) begin
				assert (int'(pix_x) == ras_x && int'(pix_y) == ras_y &&
					pixel_req == (ras_x < vga_pkg::H_ACTIVE && ras_y < vga_pkg::V_ACTIVE))
				else begin
					err_sync <= err_sync + 1;
					show_error($sformatf("request (%0d,%0d) req %0b, expected (%0d,%0d)",
						pix_x, pix_y, pixel_req, ras_x, ras_y));
				end
				if (ras_x == vga_pkg::H_TOTAL - 1) begin
					ras_x <= 0;
					ras_y <= (ras_y == vga_pkg::V_TOTAL - 1) ? 0 : ras_y + 1;
				end else begin
					ras_x <= ras_x + 1;
				end
			end
			// Output pixels, once the history holds real requests
			if (fill == FILL_CYCLES) begin
				hist_act = int'(hist[2][9:0]) < vga_pkg::H_ACTIVE &&
					int'(hist[2][19:10]) < vga_pkg::V_ACTIVE;
				exp_rgb = expected_rgb(int'(hist[2][9:0]), int'(hist[2][19:10]), hist_act);
				assert ({vga_r, vga_g, vga_b} == exp_rgb) else begin
					if (bar_rows(int'(hist[2][19:10]))) begin
						err_bars <= err_bars + 1;
					end else begin
						err_outline <= err_outline + 1;
					end
					// Only the first few, a broken path fails every pixel
					if (err_bars + err_outline < 10) begin
						show_error($sformatf("pixel (%0d,%0d) is %h, expected %h",
							hist[2][9:0], hist[2][19:10], {vga_r, vga_g, vga_b}, exp_rgb));
					end
				end
				assert (vga_blank_n == hist_act)
				else begin
					err_sync <= err_sync + 1;
					show_error($sformatf("vga_blank_n is %0b at (%0d,%0d)",
						vga_blank_n, hist[2][9:0], hist[2][19:10]));
				end
			end
			// Horizontal sync, width on the rising edge, period between falls
			hs_prev <= vga_hs;
			hs_low  <= vga_hs ? 0 : hs_low + 1;
			if (vga_hs && !hs_prev) begin
				assert (hs_low == vga_pkg::H_SYNC) else begin
					err_sync <= err_sync + 1;
					show_error($sformatf("hsync low for %0d cycles", hs_low));
				end
			end
			if (!vga_hs && hs_prev) begin
				if (hs_falls > 0) begin
					assert (hs_gap == vga_pkg::H_TOTAL) else begin
						err_sync <= err_sync + 1;
						show_error($sformatf("hsync period %0d cycles", hs_gap));
					end
				end
				hs_gap   <= 1;
				hs_falls <= hs_falls + 1;
			end else begin
				hs_gap <= hs_gap + 1;
			end
			// Vertical sync, counted in pixel cycles
			vs_prev <= vga_vs;
			vs_low  <= vga_vs ? 0 : vs_low + 1;
			if (vga_vs && !vs_prev) begin
				assert (vs_low == vga_pkg::V_SYNC * vga_pkg::H_TOTAL) else begin
					err_sync <= err_sync + 1;
					show_error($sformatf("vsync low for %0d cycles", vs_low));
				end
			end
			if (!vga_vs && vs_prev) begin
				if (vs_falls > 0) begin
					assert (vs_gap == vga_pkg::V_TOTAL * vga_pkg::H_TOTAL) else begin
						err_sync <= err_sync + 1;
						show_error($sformatf("vsync period %0d cycles", vs_gap));
					end
				end
				vs_gap   <= 1;
				vs_falls <= vs_falls + 1;
			end else begin
				vs_gap <= vs_gap + 1;
			end
		end
	end

	//======================================================================
	// Stimulus
	//======================================================================

	task automatic check_segments(input int a, input int b);
		@(posedge clk);
		score_a <= a[6:0];
		score_b <= b[6:0];
		@(posedge clk);
		assert (hex0 == digit_pattern(a, 1'b0) && hex1 == digit_pattern(a, 1'b1) &&
			hex2 == digit_pattern(b, 1'b0) && hex3 == digit_pattern(b, 1'b1)) else begin
			err_seg++;
			show_error($sformatf("scores %0d/%0d show %h %h %h %h", a, b, hex3, hex2, hex1, hex0));
		end
	endtask

	// Raster reaches the setup line, all active pixels done
	task automatic wait_setup_line();
		do begin
			@(posedge clk);
		end while (!(int'(pix_y) == SETUP_LINE && pix_x == '0));
	endtask

	// Next square, enables and scores; frame 2 is empty with both features off
	task automatic draw_frame(input int n);
		int x0;
		int y0;
		int r;
		prev_on    <= sq_on;
		box_x0     <= sq_x0;
		box_x1     <= sq_x1;
		box_y0     <= sq_y0;
		box_y1     <= sq_y1;
		x0 = 16 + int'({$random(seed)} % 560);
		y0 = 20 + int'({$random(seed)} % 400);
		sq_x0      <= x0;
		sq_y0      <= y0;
		sq_x1      <= x0 + 4 + int'({$random(seed)} % 60);
		sq_y1      <= y0 + 4 + int'({$random(seed)} % 50);
		sq_on      <= (n != 2);
		detect_en  <= (n != 2);
		overlay_en <= (n != 2);
		r = $random(seed);
		score_a    <= r[6:0];
		r = $random(seed);
		score_b    <= r[6:0];
	endtask

	initial begin
		seed        = 44;
		rst_n       = 1'b0;
		detect_en   = 1'b0;
		overlay_en  = 1'b0;
		score_a     = '0;
		score_b     = '0;
		err_sync    = 0;
		err_outline = 0;
		err_bars    = 0;
		err_ball    = 0;
		err_seg     = 0;
		err_misc    = 0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		// Row 0 is free of bars, scores may change here
		check_segments(0, 123);
		check_segments(7, 99);
		check_segments(42, 42);
		check_segments(99, 7);
		check_segments(123, 0);
		report_test("seven_segment", err_seg);

		draw_frame(0);
		for (frame = 0; frame < 4; frame++) begin
			wait_setup_line();
			assert (ball_found == sq_on) else begin
				err_ball++;
				show_error($sformatf("frame %0d ball_found is %0b", frame, ball_found));
			end
			if (sq_on) begin
				assert (int'(ball_x) == (sq_x0 + sq_x1) / 2 &&
					int'(ball_y) == (sq_y0 + sq_y1) / 2) else begin
					err_ball++;
					show_error($sformatf("frame %0d center (%0d,%0d), expected (%0d,%0d)",
						frame, ball_x, ball_y, (sq_x0 + sq_x1) / 2, (sq_y0 + sq_y1) / 2));
				end
			end
			if (frame < 3) begin
				draw_frame(frame + 1);
			end
		end
		report_test("ball_result", err_ball);
		report_test("outline", err_outline);
		report_test("score_bars", err_bars);
		if (vs_falls < 2) begin
			$display("Sync check incomplete, fewer than two vertical sync pulses seen");
			err_misc = 1;
		end
		report_test("sync_timing", err_sync + err_misc);

		total  = err_seg + err_ball + err_outline + err_bars + err_sync + err_misc;
		failed = int'(err_seg != 0) + int'(err_ball != 0) + int'(err_outline != 0) +
			int'(err_bars != 0) + int'(err_sync + err_misc != 0);
		$display("Tests run: 5, failed: %0d, errors: %0d", failed, total);
		if (total == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- vga_pkg.sv
package vga_pkg;

	//======================================================================
	// 640x480 VGA timing
	//======================================================================

	// Horizontal, in pixels
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// Vertical, in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// Wide enough for 799 and 524
	localparam int COORD_W = 10;
	localparam int COLOR_W = 8;

	//======================================================================
	// Ball color and outline
	//======================================================================

	// Strong red, weak green and blue
	localparam int BALL_R_MIN  = 200;
	localparam int BALL_GB_MAX = 80;

	// Outline drawn in pure green
	localparam logic [COLOR_W-1:0] MARK_R = 8'd0;
	localparam logic [COLOR_W-1:0] MARK_G = 8'd255;
	localparam logic [COLOR_W-1:0] MARK_B = 8'd0;

	//======================================================================
	// Score bars and seven-segment readout
	//======================================================================

	// Bar rows, inclusive
	localparam int BAR_TOP    = 8;
	localparam int BAR_BOTTOM = 15;
	// Bar A grows right from here, bar B grows left from here
	localparam int BAR_LEFT   = 8;
	localparam int BAR_RIGHT  = 632;
	localparam int BAR_STEP   = 3;

	localparam int SCORE_W   = 7;
	localparam int SCORE_MAX = 99;

	// Packed as {r, g, b}
	localparam logic [3*COLOR_W-1:0] BAR_A_COLOR = {8'd255, 8'd255, 8'd255};
	localparam logic [3*COLOR_W-1:0] BAR_B_COLOR = {8'd255, 8'd255, 8'd0};

	// Active low, bit 0 is segment a
	localparam logic [6:0] SEG_DIGITS [10] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
		7'h12, 7'h02, 7'h78, 7'h00, 7'h10
	};
	// Only segment g lit
	localparam logic [6:0] SEG_DASH = 7'h3f;

endpackage

//--- vga_timing.sv
module vga_timing (
	input  logic                        vga_clk,
	input  logic                        rst_n,
	output logic [vga_pkg::COORD_W-1:0] pix_x,
	output logic [vga_pkg::COORD_W-1:0] pix_y,
	output logic                        pixel_req,
	output logic                        hs,
	output logic                        vs
);

	// Raster position
	logic [vga_pkg::COORD_W-1:0] h_cnt;
	logic [vga_pkg::COORD_W-1:0] v_cnt;

	// Decodes of the current position
	logic h_last;
	logic v_last;
	logic active;
	logic h_sync_on;
	logic v_sync_on;

	assign h_last = int'(h_cnt) == vga_pkg::H_TOTAL - 1;
	assign v_last = int'(v_cnt) == vga_pkg::V_TOTAL - 1;
	assign active = int'(h_cnt) < vga_pkg::H_ACTIVE && int'(v_cnt) < vga_pkg::V_ACTIVE;

	// Sync windows start right after the front porch
	assign h_sync_on = int'(h_cnt) >= vga_pkg::H_ACTIVE + vga_pkg::H_FRONT &&
		int'(h_cnt) < vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_SYNC;
	assign v_sync_on = int'(v_cnt) >= vga_pkg::V_ACTIVE + vga_pkg::V_FRONT &&
		int'(v_cnt) < vga_pkg::V_ACTIVE + vga_pkg::V_FRONT + vga_pkg::V_SYNC;

	//======================================================================
	// Counters
	//======================================================================

	always_ff @(posedge vga_clk) begin
		if (!rst_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (h_last) begin
			h_cnt <= '0;
			// Line wrap, frame wrap on the last line
			if (v_last) begin
				v_cnt <= '0;
			end else begin
				v_cnt <= v_cnt + 1'b1;
			end
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	//======================================================================
	// Registered outputs
	//======================================================================

	always_ff @(posedge vga_clk) begin
		if (!rst_n) begin
			pix_x     <= '0;
			pix_y     <= '0;
			pixel_req <= 1'b0;
			hs        <= 1'b1;
			vs        <= 1'b1;
		end else begin
			pix_x     <= h_cnt;
			pix_y     <= v_cnt;
			// Request a pixel only inside 640x480
			pixel_req <= active;
			// Syncs active low
			hs        <= !h_sync_on;
			vs        <= !v_sync_on;
		end
	end

	// Line counter wraps before the period ends
	a_h_range: assert property (@(posedge vga_clk) disable iff (!rst_n)
		int'(h_cnt) < vga_pkg::H_TOTAL);

endmodule
